// ==== common/fpu_params.svh ====
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// --------------------
// Datapath sizes
// --------------------
`define FPU_FLEN     64
`define FPU_REG_NUM  32
`define FPU_IDX_W    5

// Issue tag, wraps freely
`define FPU_TAG_W    4

// Write-back buses: init, fast, slow
`define FPU_TGT_NUM  3

// Cycles from EX2 to slow result
`define FPU_CMP_LAT  2

`endif

// ==== common/fpu_pkg.sv ====
`include "fpu_params.svh"

package fpu_pkg;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_typ_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_FMV_X_W,
    OP_FMV_W_X,
    OP_FMV_X_D,
    OP_FMV_D_X,
    OP_FSGNJ_S,
    OP_FSGNJN_S,
    OP_FSGNJX_S,
    OP_FSGNJ_D,
    OP_FSGNJN_D,
    OP_FSGNJX_D,
    OP_FEQ_D,
    OP_FLT_D,
    OP_FLE_D,
    OP_FMIN_D,
    OP_FMAX_D
  } fpu_op_t;

  typedef enum logic {
    PIPE_FAST = 1'b0,
    PIPE_SLOW = 1'b1
  } pipe_sel_t;

  // Architectural register reference
  typedef struct packed {
    logic                  valid;
    reg_typ_t              typ;
    logic [`FPU_IDX_W-1:0] idx;
  } reg_desc_t;

  typedef struct packed {
    logic                  valid;
    logic [`FPU_TAG_W-1:0] tag;
    logic [31:0]           inst;
    reg_desc_t             rs1;
    reg_desc_t             rs2;
    reg_desc_t             wr_reg;
  } issue_t;

  typedef struct packed {
    fpu_op_t   op;
    pipe_sel_t pipe;
  } pipe_ctrl_t;

  typedef struct packed {
    logic                  valid;
    reg_typ_t              rd_type;
    logic [`FPU_IDX_W-1:0] rd_idx;
    logic [`FPU_FLEN-1:0]  rd_data;
  } phy_wr_t;

  // Write-back plus completion info
  typedef struct packed {
    phy_wr_t               wr;
    logic [`FPU_TAG_W-1:0] tag;
    logic [4:0]            fflags;   // NV DZ OF UF NX
  } result_t;

endpackage

// ==== logic/fpu_decoder.sv ====
module fpu_decoder (
  input  logic [31:0]         i_inst,
  output fpu_pkg::pipe_ctrl_t o_ctrl
);
  import fpu_pkg::*;

  logic [6:0] w_opcode;
  logic [6:0] w_funct7;
  logic [2:0] w_funct3;
  logic [4:0] w_rs2;

  assign w_opcode = i_inst[6:0];
  assign w_funct7 = i_inst[31:25];
  assign w_funct3 = i_inst[14:12];
  assign w_rs2    = i_inst[24:20];

  always_comb begin
    o_ctrl.op   = OP_NONE;
    o_ctrl.pipe = PIPE_FAST;
    if (w_opcode == 7'b1010011) begin  // OP-FP
      case (w_funct7)
        7'b0010000 : begin
          case (w_funct3)
            3'b000  : o_ctrl.op = OP_FSGNJ_S;
            3'b001  : o_ctrl.op = OP_FSGNJN_S;
            3'b010  : o_ctrl.op = OP_FSGNJX_S;
            default : o_ctrl.op = OP_NONE;
          endcase
        end
        7'b0010001 : begin
          case (w_funct3)
            3'b000  : o_ctrl.op = OP_FSGNJ_D;
            3'b001  : o_ctrl.op = OP_FSGNJN_D;
            3'b010  : o_ctrl.op = OP_FSGNJX_D;
            default : o_ctrl.op = OP_NONE;
          endcase
        end
        7'b0010101 : begin
          if (w_funct3 == 3'b000) begin
            o_ctrl = '{op: OP_FMIN_D, pipe: PIPE_SLOW};
          end else if (w_funct3 == 3'b001) begin
            o_ctrl = '{op: OP_FMAX_D, pipe: PIPE_SLOW};
          end
        end
        7'b1010001 : begin
          case (w_funct3)
            3'b010  : o_ctrl = '{op: OP_FEQ_D, pipe: PIPE_SLOW};
            3'b001  : o_ctrl = '{op: OP_FLT_D, pipe: PIPE_SLOW};
            3'b000  : o_ctrl = '{op: OP_FLE_D, pipe: PIPE_SLOW};
            default : o_ctrl = '{op: OP_NONE, pipe: PIPE_FAST};
          endcase
        end
        // Moves need rs2 and funct3 zero
        7'b1110000 : o_ctrl.op = (w_rs2 == '0 && w_funct3 == '0) ? OP_FMV_X_W : OP_NONE;
        7'b1111000 : o_ctrl.op = (w_rs2 == '0 && w_funct3 == '0) ? OP_FMV_W_X : OP_NONE;
        7'b1110001 : o_ctrl.op = (w_rs2 == '0 && w_funct3 == '0) ? OP_FMV_X_D : OP_NONE;
        7'b1111001 : o_ctrl.op = (w_rs2 == '0 && w_funct3 == '0) ? OP_FMV_D_X : OP_NONE;
        default    : o_ctrl.op = OP_NONE;
      endcase
    end
  end

endmodule

// ==== logic/operand_fwd.sv ====
`include "fpu_params.svh"

module operand_fwd (
  input  fpu_pkg::reg_desc_t   i_src,
  input  fpu_pkg::phy_wr_t     i_tgt[`FPU_TGT_NUM],
  input  logic [`FPU_FLEN-1:0] i_rf_data,
  output logic [`FPU_FLEN-1:0] o_data
);
  import fpu_pkg::*;

  logic [`FPU_TGT_NUM-1:0] w_hit;
  logic [`FPU_FLEN-1:0]    w_fwd_data;
  logic                    w_src_x0;

  // x0 never takes a forwarded value
  assign w_src_x0 = (i_src.typ == GPR) && (i_src.idx == '0);

  always_comb begin
    w_fwd_data = '0;
    for (int t = 0; t < `FPU_TGT_NUM; t++) begin
      w_hit[t] = i_src.valid & ~w_src_x0 & i_tgt[t].valid &
                 (i_tgt[t].rd_type == i_src.typ) &
                 (i_tgt[t].rd_idx == i_src.idx);
      w_fwd_data = w_fwd_data | ({`FPU_FLEN{w_hit[t]}} & i_tgt[t].rd_data);
    end
  end

  assign o_data = (|w_hit) ? w_fwd_data : i_rf_data;  // Bus beats register file

endmodule

// ==== logic/fp_regfile.sv ====
`include "fpu_params.svh"

module fp_regfile (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fpu_pkg::phy_wr_t      i_wr[`FPU_TGT_NUM],
  input  fpu_pkg::reg_typ_t     i_rd_typ[2],
  input  logic [`FPU_IDX_W-1:0] i_rd_idx[2],
  output logic [`FPU_FLEN-1:0]  o_rd_data[2]
);
  import fpu_pkg::*;

  // Bank 0 is integer, bank 1 floating point
  logic [`FPU_FLEN-1:0] r_regs[2][`FPU_REG_NUM];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int b = 0; b < 2; b++) begin
        for (int r = 0; r < `FPU_REG_NUM; r++) begin
          r_regs[b][r] <= '0;
        end
      end
    end else begin
      for (int p = 0; p < `FPU_TGT_NUM; p++) begin  // Last port wins
        if (i_wr[p].valid) begin
          r_regs[i_wr[p].rd_type][i_wr[p].rd_idx] <= i_wr[p].rd_data;
        end
      end
    end
  end

  // --------------------
  // Write-through read
  // --------------------
  always_comb begin
    for (int rp = 0; rp < 2; rp++) begin
      o_rd_data[rp] = r_regs[i_rd_typ[rp]][i_rd_idx[rp]];
      for (int p = 0; p < `FPU_TGT_NUM; p++) begin
        if (i_wr[p].valid && (i_wr[p].rd_type == i_rd_typ[rp]) &&
            (i_wr[p].rd_idx == i_rd_idx[rp])) begin
          o_rd_data[rp] = i_wr[p].rd_data;
        end
      end
      if ((i_rd_typ[rp] == GPR) && (i_rd_idx[rp] == '0)) begin
        o_rd_data[rp] = '0;  // x0
      end
    end
  end

endmodule

// ==== fpu_pipe/fpu_cmp_unit.sv ====
`include "fpu_params.svh"

module fpu_cmp_unit (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_valid,
  input  fpu_pkg::pipe_ctrl_t   i_ctrl,
  input  logic [`FPU_TAG_W-1:0] i_tag,
  input  fpu_pkg::reg_desc_t    i_rd,
  input  logic [`FPU_FLEN-1:0]  i_rs1,
  input  logic [`FPU_FLEN-1:0]  i_rs2,
  output fpu_pkg::result_t      o_res
);
  import fpu_pkg::*;

  typedef struct packed {
    logic nan1;
    logic nan2;
    logic snan;       // Either input
    logic both_zero;
    logic lt;         // Total order, -0 below +0
    logic eq;         // Bitwise
  } cls_t;

  typedef struct packed {
    logic                  valid;
    logic [`FPU_TAG_W-1:0] tag;
    reg_desc_t             rd;
    fpu_op_t               op;
  } meta_t;

  cls_t                 w_cls;
  cls_t                 r_cls;
  meta_t                w_meta;
  meta_t                r_meta[`FPU_CMP_LAT];
  logic [`FPU_FLEN-1:0] r_rs1;
  logic [`FPU_FLEN-1:0] r_rs2;
  logic                 w_any_nan;
  logic                 w_flt;
  logic                 w_feq;
  logic [`FPU_FLEN-1:0] w_res_data;
  logic [4:0]           w_res_flags;
  logic [`FPU_FLEN-1:0] r_res_data;
  logic [4:0]           r_res_flags;

  function automatic logic is_nan(logic [63:0] v);
    return (&v[62:52]) & (|v[51:0]);
  endfunction

  function automatic logic is_snan(logic [63:0] v);
    return is_nan(v) & ~v[51];
  endfunction

  // --------------------
  // Stage 1 classify
  // --------------------
  always_comb begin
    w_cls.nan1      = is_nan(i_rs1);
    w_cls.nan2      = is_nan(i_rs2);
    w_cls.snan      = is_snan(i_rs1) | is_snan(i_rs2);
    w_cls.both_zero = ~(|i_rs1[62:0]) & ~(|i_rs2[62:0]);
    w_cls.eq        = (i_rs1 == i_rs2);
    if (i_rs1[63] != i_rs2[63]) begin
      w_cls.lt = i_rs1[63];
    end else if (i_rs1[63]) begin
      w_cls.lt = i_rs1[62:0] > i_rs2[62:0];  // Both negative
    end else begin
      w_cls.lt = i_rs1[62:0] < i_rs2[62:0];
    end
  end

  always_comb begin
    w_meta.valid = i_valid;
    w_meta.tag   = i_tag;
    w_meta.rd    = i_rd;
    w_meta.op    = i_ctrl.op;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < `FPU_CMP_LAT; s++) begin
        r_meta[s] <= '0;
      end
    end else begin
      r_meta[0] <= w_meta;
      for (int s = 1; s < `FPU_CMP_LAT; s++) begin
        r_meta[s] <= r_meta[s-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_cls <= w_cls;
    r_rs1 <= i_rs1;
    r_rs2 <= i_rs2;
  end

  // --------------------
  // Stage 2 result
  // --------------------
  assign w_any_nan = r_cls.nan1 | r_cls.nan2;
  assign w_flt     = ~w_any_nan & r_cls.lt & ~r_cls.both_zero;  // IEEE, zeros equal
  assign w_feq     = ~w_any_nan & (r_cls.eq | r_cls.both_zero);

  always_comb begin
    w_res_data  = '0;
    w_res_flags = '0;
    case (r_meta[0].op)
      OP_FEQ_D : begin
        w_res_data     = {{(`FPU_FLEN-1){1'b0}}, w_feq};
        w_res_flags[4] = r_cls.snan;  // Quiet compare
      end
      OP_FLT_D : begin
        w_res_data     = {{(`FPU_FLEN-1){1'b0}}, w_flt};
        w_res_flags[4] = r_cls.snan | w_any_nan;
      end
      OP_FLE_D : begin
        w_res_data     = {{(`FPU_FLEN-1){1'b0}}, w_flt | w_feq};
        w_res_flags[4] = r_cls.snan | w_any_nan;
      end
      OP_FMIN_D,
      OP_FMAX_D : begin
        w_res_flags[4] = r_cls.snan;
        if (r_cls.nan1 && r_cls.nan2) begin
          w_res_data = 64'h7ff80000_00000000;
        end else if (r_cls.nan1) begin
          w_res_data = r_rs2;
        end else if (r_cls.nan2) begin
          w_res_data = r_rs1;
        end else if ((r_meta[0].op == OP_FMIN_D) == r_cls.lt) begin
          w_res_data = r_rs1;
        end else begin
          w_res_data = r_rs2;
        end
      end
      default : w_res_data = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    r_res_data  <= w_res_data;
    r_res_flags <= w_res_flags;
  end

  always_comb begin
    o_res.wr.valid   = r_meta[`FPU_CMP_LAT-1].valid;
    o_res.wr.rd_type = r_meta[`FPU_CMP_LAT-1].rd.typ;
    o_res.wr.rd_idx  = r_meta[`FPU_CMP_LAT-1].rd.idx;
    o_res.wr.rd_data = r_res_data;
    o_res.tag        = r_meta[`FPU_CMP_LAT-1].tag;
    o_res.fflags     = r_res_flags;
  end

endmodule

// ==== fpu_pipe/fpu_pipe.sv ====
`include "fpu_params.svh"

module fpu_pipe (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fpu_pkg::issue_t       i_issue,
  output fpu_pkg::reg_typ_t     o_rd_typ[2],
  output logic [`FPU_IDX_W-1:0] o_rd_idx[2],
  input  logic [`FPU_FLEN-1:0]  i_rd_data[2],
  input  fpu_pkg::phy_wr_t      i_tgt[`FPU_TGT_NUM],
  output fpu_pkg::result_t      o_fast_res,
  output fpu_pkg::result_t      o_slow_res
);
  import fpu_pkg::*;

  pipe_ctrl_t           w_ex0_ctrl;
  pipe_ctrl_t           r_ex1_ctrl;
  pipe_ctrl_t           r_ex2_ctrl;
  pipe_ctrl_t           r_ex3_ctrl;
  issue_t               r_ex1_issue;
  issue_t               r_ex2_issue;
  issue_t               r_ex3_issue;

  logic [`FPU_FLEN-1:0] r_ex2_rs1;
  logic [`FPU_FLEN-1:0] r_ex2_rs2;
  logic [`FPU_FLEN-1:0] w_ex2_rs1;
  logic [`FPU_FLEN-1:0] w_ex2_rs2;
  logic [`FPU_FLEN-1:0] w_ex2_rs1_box;
  logic [`FPU_FLEN-1:0] w_ex2_rs2_box;
  logic [`FPU_FLEN-1:0] w_ex2_res;
  logic [`FPU_FLEN-1:0] r_ex3_res;

  // --------------------
  // EX0
  // --------------------
  fpu_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex2_issue <= '0;
      r_ex3_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_ctrl  <= '0;
      r_ex3_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex2_issue <= r_ex1_issue;
      r_ex3_issue <= r_ex2_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex3_ctrl  <= r_ex2_ctrl;
    end
  end

  // --------------------
  // EX1 register read
  // --------------------
  assign o_rd_typ[0] = r_ex1_issue.rs1.typ;
  assign o_rd_idx[0] = r_ex1_issue.rs1.idx;
  assign o_rd_typ[1] = r_ex1_issue.rs2.typ;
  assign o_rd_idx[1] = r_ex1_issue.rs2.idx;

  always_ff @(posedge i_clk) begin
    r_ex2_rs1 <= i_rd_data[0];
    r_ex2_rs2 <= i_rd_data[1];
  end

  // --------------------
  // EX2
  // --------------------
  operand_fwd u_fwd_rs1 (
    .i_src     (r_ex2_issue.rs1),
    .i_tgt     (i_tgt),
    .i_rf_data (r_ex2_rs1),
    .o_data    (w_ex2_rs1)
  );

  operand_fwd u_fwd_rs2 (
    .i_src     (r_ex2_issue.rs2),
    .i_tgt     (i_tgt),
    .i_rf_data (r_ex2_rs2),
    .o_data    (w_ex2_rs2)
  );

  // Unboxed singles read as canonical NaN
  assign w_ex2_rs1_box = (&w_ex2_rs1[63:32]) ? w_ex2_rs1 : 64'hffffffff_7fc00000;
  assign w_ex2_rs2_box = (&w_ex2_rs2[63:32]) ? w_ex2_rs2 : 64'hffffffff_7fc00000;

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_FMV_X_W  : w_ex2_res = {{32{w_ex2_rs1[31]}}, w_ex2_rs1[31:0]};
      OP_FMV_W_X  : w_ex2_res = {32'hffffffff, w_ex2_rs1[31:0]};
      OP_FMV_X_D,
      OP_FMV_D_X  : w_ex2_res = w_ex2_rs1;
      OP_FSGNJ_S  : w_ex2_res = {w_ex2_rs1_box[63:32], w_ex2_rs2_box[31], w_ex2_rs1_box[30:0]};
      OP_FSGNJN_S : w_ex2_res = {w_ex2_rs1_box[63:32], ~w_ex2_rs2_box[31], w_ex2_rs1_box[30:0]};
      OP_FSGNJX_S : begin
        w_ex2_res = {w_ex2_rs1_box[63:32], w_ex2_rs1_box[31] ^ w_ex2_rs2_box[31],
                     w_ex2_rs1_box[30:0]};
      end
      OP_FSGNJ_D  : w_ex2_res = {w_ex2_rs2[63], w_ex2_rs1[62:0]};
      OP_FSGNJN_D : w_ex2_res = {~w_ex2_rs2[63], w_ex2_rs1[62:0]};
      OP_FSGNJX_D : w_ex2_res = {w_ex2_rs1[63] ^ w_ex2_rs2[63], w_ex2_rs1[62:0]};
      default     : w_ex2_res = '0;  // Slow ops and OP_NONE
    endcase
  end

  fpu_cmp_unit u_cmp_unit (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (r_ex2_issue.valid & (r_ex2_ctrl.pipe == PIPE_SLOW)),
    .i_ctrl    (r_ex2_ctrl),
    .i_tag     (r_ex2_issue.tag),
    .i_rd      (r_ex2_issue.wr_reg),
    .i_rs1     (w_ex2_rs1),
    .i_rs2     (w_ex2_rs2),
    .o_res     (o_slow_res)
  );

  // --------------------
  // EX3
  // --------------------
  always_ff @(posedge i_clk) begin
    r_ex3_res <= w_ex2_res;
  end

  always_comb begin
    o_fast_res.wr.valid   = r_ex3_issue.valid & (r_ex3_ctrl.pipe == PIPE_FAST);
    o_fast_res.wr.rd_type = r_ex3_issue.wr_reg.typ;
    o_fast_res.wr.rd_idx  = r_ex3_issue.wr_reg.idx;
    o_fast_res.wr.rd_data = r_ex3_res;
    o_fast_res.tag        = r_ex3_issue.tag;
    o_fast_res.fflags     = '0;  // Moves and sign injection never raise
  end

endmodule

// ==== logic/fpu_top.sv ====
`include "fpu_params.svh"

module fpu_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  fpu_pkg::issue_t  i_issue,
  input  fpu_pkg::phy_wr_t i_init_wr,
  output fpu_pkg::result_t o_fast_res,
  output fpu_pkg::result_t o_slow_res
);
  import fpu_pkg::*;

  phy_wr_t               w_tgt[`FPU_TGT_NUM];
  reg_typ_t              w_rd_typ[2];
  logic [`FPU_IDX_W-1:0] w_rd_idx[2];
  logic [`FPU_FLEN-1:0]  w_rd_data[2];

  // Write-back loop: init, fast, slow
  assign w_tgt[0] = i_init_wr;
  assign w_tgt[1] = o_fast_res.wr;
  assign w_tgt[2] = o_slow_res.wr;

  fp_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_tgt),
    .i_rd_typ  (w_rd_typ),
    .i_rd_idx  (w_rd_idx),
    .o_rd_data (w_rd_data)
  );

  fpu_pipe u_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .o_rd_typ   (w_rd_typ),
    .o_rd_idx   (w_rd_idx),
    .i_rd_data  (w_rd_data),
    .i_tgt      (w_tgt),
    .o_fast_res (o_fast_res),
    .o_slow_res (o_slow_res)
  );

endmodule

// ==== tb/fpu_tb_clk.sv ====
module fpu_tb_clk (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // Period 20
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (10) @(posedge o_clk);
    #2 o_reset_n = 1'b1;
  end

endmodule

// ==== tb/fpu_chk.sv ====
module fpu_chk (
  input logic             i_clk,
  input logic             i_reset_n,
  input fpu_pkg::issue_t  i_issue,
  input fpu_pkg::result_t i_fast_res,
  input fpu_pkg::result_t i_slow_res
);
  import fpu_pkg::*;

  // Quiet buses while in reset
  a_reset_idle : assert property (@(posedge i_clk)
    !i_reset_n |-> !(i_fast_res.wr.valid || i_slow_res.wr.valid))
    else $error("result bus valid during reset");

  // Fast result 3 cycles after issue with that issue's tag
  a_fast_lat : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fast_res.wr.valid |-> $past(i_issue.valid, 3) &&
                            (i_fast_res.tag == $past(i_issue.tag, 3)))
    else $error("fast result without matching issue 3 cycles before");

  // Slow result 4 cycles after issue
  a_slow_lat : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_slow_res.wr.valid |-> $past(i_issue.valid, 4) &&
                            (i_slow_res.tag == $past(i_issue.tag, 4)))
    else $error("slow result without matching issue 4 cycles before");

endmodule

// ==== tb/fpu_tb.sv ====
module fpu_tb;
  import fpu_pkg::*;

  typedef struct packed {
    result_t     res;
    logic [31:0] due;
  } exp_t;

  localparam int N_MOVE   = 7 + 16;
  localparam int N_SGNJ   = 64;
  localparam int N_CMP    = 7 + 48;
  localparam int N_MINMAX = 7 + 24;
  localparam int N_FWD    = 8;
  localparam int N_STREAM = 96;
  localparam int N_ISSUE  = N_MOVE + N_SGNJ + N_CMP + N_MINMAX + N_FWD + N_STREAM;
  localparam int LIMIT    = 4 * N_ISSUE + 100;

  logic        clk;
  logic        reset_n;
  issue_t      issue;
  phy_wr_t     init_wr;
  result_t     fast_res;
  result_t     slow_res;

  logic [63:0] shadow[2][32];  // Both register files
  logic [31:0] seed;
  logic [31:0] cyc = 0;
  logic [3:0]  tag_cnt;
  exp_t        fast_q[$];
  exp_t        slow_q[$];
  int          err_val;
  int          err_time;
  int          err_missing;
  int          err_extra;

  fpu_tb_clk u_clk (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  fpu_top u_fpu_top (
    .i_clk      (clk),
    .i_reset_n  (reset_n),
    .i_issue    (issue),
    .i_init_wr  (init_wr),
    .o_fast_res (fast_res),
    .o_slow_res (slow_res)
  );

  bind fpu_top fpu_chk u_chk (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .i_fast_res (o_fast_res),
    .i_slow_res (o_slow_res)
  );

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [4:0] rand_idx(int lo, int span);
    return 5'(lo + (lcg_next() >> 8) % span);
  endfunction

  // Random data mixed with NaNs, zeros and unboxed singles
  function automatic logic [63:0] rand_val();
    logic [31:0] r;
    logic [31:0] lo;
    r  = lcg_next();
    lo = lcg_next();
    case (r[19:16])
      4'd0    : return {r[31], 11'h7ff, 1'b1, 51'(lo)};             // qNaN
      4'd1    : return {r[31], 11'h7ff, 1'b0, 19'h0, lo | 32'h1};   // sNaN
      4'd2    : return 64'h0;
      4'd3    : return 64'h8000000000000000;
      4'd4    : return {r ^ 32'h5a5a0000, lo};
      4'd5,
      4'd6    : return {32'hffffffff, lo};
      default : return {lcg_next(), lo};
    endcase
  endfunction

  function automatic reg_typ_t dst_typ(fpu_op_t op);
    case (op)
      OP_FMV_X_W, OP_FMV_X_D, OP_FEQ_D, OP_FLT_D, OP_FLE_D : return GPR;
      default : return FPR;
    endcase
  endfunction

  function automatic reg_typ_t src_typ(fpu_op_t op);
    return (op == OP_FMV_W_X || op == OP_FMV_D_X) ? GPR : FPR;
  endfunction

  function automatic logic has_rs2(fpu_op_t op);
    return !(op inside {OP_FMV_X_W, OP_FMV_W_X, OP_FMV_X_D, OP_FMV_D_X});
  endfunction

  function automatic logic slow_op(fpu_op_t op);
    return op inside {OP_FEQ_D, OP_FLT_D, OP_FLE_D, OP_FMIN_D, OP_FMAX_D};
  endfunction

  function automatic logic [31:0] encode(fpu_op_t op, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    case (op)
      OP_FMV_X_W                           : f7 = 7'b1110000;
      OP_FMV_W_X                           : f7 = 7'b1111000;
      OP_FMV_X_D                           : f7 = 7'b1110001;
      OP_FMV_D_X                           : f7 = 7'b1111001;
      OP_FSGNJ_S, OP_FSGNJN_S, OP_FSGNJX_S : f7 = 7'b0010000;
      OP_FSGNJ_D, OP_FSGNJN_D, OP_FSGNJX_D : f7 = 7'b0010001;
      OP_FMIN_D, OP_FMAX_D                 : f7 = 7'b0010101;
      OP_FEQ_D, OP_FLT_D, OP_FLE_D         : f7 = 7'b1010001;
      default                              : f7 = 7'b0;
    endcase
    case (op)
      OP_FSGNJN_S, OP_FSGNJN_D, OP_FMAX_D, OP_FLT_D : f3 = 3'b001;
      OP_FSGNJX_S, OP_FSGNJX_D, OP_FEQ_D            : f3 = 3'b010;
      default                                       : f3 = 3'b000;
    endcase
    return {f7, has_rs2(op) ? rs2 : 5'd0, rs1, f3, rd, 7'b1010011};
  endfunction

  function automatic logic [63:0] rd_shadow(reg_typ_t t, logic [4:0] i);
    return (t == GPR && i == 0) ? 64'h0 : shadow[t][i];
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic logic is_nan64(logic [63:0] v);
    return (v[62:52] == 11'h7ff) && (v[51:0] != 0);
  endfunction

  function automatic logic is_snan64(logic [63:0] v);
    return is_nan64(v) && !v[51];
  endfunction

  function automatic logic [63:0] box_s(logic [63:0] v);
    return (v[63:32] == 32'hffffffff) ? v : 64'hffffffff7fc00000;
  endfunction

  // Sign-magnitude order with -0 below +0
  function automatic logic order_lt(logic [63:0] a, logic [63:0] b);
    if (a[63] != b[63]) return a[63];
    return a[63] ? (a[62:0] > b[62:0]) : (a[62:0] < b[62:0]);
  endfunction

  function automatic result_t ref_result(fpu_op_t op, logic [4:0] rd, logic [3:0] tag,
                                         logic [63:0] a, logic [63:0] b);
    result_t     r;
    logic [63:0] sa;
    logic [63:0] sb;
    logic        any_nan;
    logic        zeros;
    logic        lt;
    logic        eq;
    r            = '0;
    r.wr.valid   = 1'b1;
    r.wr.rd_type = dst_typ(op);
    r.wr.rd_idx  = rd;
    r.tag        = tag;
    sa           = box_s(a);
    sb           = box_s(b);
    any_nan      = is_nan64(a) || is_nan64(b);
    zeros        = (a[62:0] == 0) && (b[62:0] == 0);
    eq           = !any_nan && (a == b || zeros);
    lt           = !any_nan && !zeros && order_lt(a, b);
    case (op)
      OP_FMV_X_W  : r.wr.rd_data = {{32{a[31]}}, a[31:0]};
      OP_FMV_W_X  : r.wr.rd_data = {32'hffffffff, a[31:0]};
      OP_FMV_X_D,
      OP_FMV_D_X  : r.wr.rd_data = a;
      OP_FSGNJ_S  : r.wr.rd_data = {sa[63:32], sb[31], sa[30:0]};
      OP_FSGNJN_S : r.wr.rd_data = {sa[63:32], !sb[31], sa[30:0]};
      OP_FSGNJX_S : r.wr.rd_data = {sa[63:32], sa[31] ^ sb[31], sa[30:0]};
      OP_FSGNJ_D  : r.wr.rd_data = {b[63], a[62:0]};
      OP_FSGNJN_D : r.wr.rd_data = {!b[63], a[62:0]};
      OP_FSGNJX_D : r.wr.rd_data = {a[63] ^ b[63], a[62:0]};
      OP_FEQ_D, OP_FLT_D, OP_FLE_D : begin
        r.wr.rd_data = (op == OP_FEQ_D) ? 64'(eq) : (op == OP_FLT_D) ? 64'(lt) : 64'(lt || eq);
        r.fflags[4]  = is_snan64(a) || is_snan64(b) || (op != OP_FEQ_D && any_nan);
      end
      default : begin  // FMIN and FMAX
        r.fflags[4] = is_snan64(a) || is_snan64(b);
        if (is_nan64(a) && is_nan64(b)) r.wr.rd_data = 64'h7ff8000000000000;
        else if (is_nan64(a)) r.wr.rd_data = b;
        else if (is_nan64(b)) r.wr.rd_data = a;
        else if (order_lt(a, b)) r.wr.rd_data = (op == OP_FMIN_D) ? a : b;
        else r.wr.rd_data = (op == OP_FMIN_D) ? b : a;
      end
    endcase
    return r;
  endfunction

  // --------------------
  // Drive tasks
  // --------------------
  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      issue   = '0;
      init_wr = '0;
    end
  endtask

  task automatic init_reg(reg_typ_t t, logic [4:0] i, logic [63:0] v);
    @(posedge clk);
    #2;
    issue   = '0;
    init_wr = '{valid: 1'b1, rd_type: t, rd_idx: i, rd_data: v};
    shadow[t][i] = v;
  endtask

  task automatic preload();
    for (int i = 1; i < 32; i++) begin
      init_reg(GPR, 5'(i), rand_val());
      init_reg(FPR, 5'(i), rand_val());
    end
    idle(1);
  endtask

  // f1..f6 hold +0, -0, qNaN, sNaN, 1.0, negative qNaN
  task automatic load_specials();
    init_reg(FPR, 5'd1, 64'h0000000000000000);
    init_reg(FPR, 5'd2, 64'h8000000000000000);
    init_reg(FPR, 5'd3, 64'h7ff8000000000001);
    init_reg(FPR, 5'd4, 64'h7ff0000000000001);
    init_reg(FPR, 5'd5, 64'h3ff0000000000000);
    init_reg(FPR, 5'd6, 64'hfff8000000000000);
    idle(1);
  endtask

  task automatic issue_op(fpu_op_t op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    issue_t      is;
    exp_t        e;
    logic [63:0] a;
    logic [63:0] b;
    a = rd_shadow(src_typ(op), rs1);
    b = has_rs2(op) ? rd_shadow(FPR, rs2) : 64'h0;
    @(posedge clk);
    #2;
    is.valid  = 1'b1;
    is.tag    = tag_cnt;
    is.inst   = encode(op, rd, rs1, rs2);
    is.rs1    = '{valid: 1'b1, typ: src_typ(op), idx: rs1};
    is.rs2    = '{valid: has_rs2(op), typ: FPR, idx: has_rs2(op) ? rs2 : 5'd0};
    is.wr_reg = '{valid: 1'b1, typ: dst_typ(op), idx: rd};
    issue     = is;
    init_wr   = '0;
    e.res     = ref_result(op, rd, tag_cnt, a, b);
    e.due     = cyc + (slow_op(op) ? 32'd4 : 32'd3);
    if (slow_op(op)) slow_q.push_back(e);
    else fast_q.push_back(e);
    shadow[dst_typ(op)][rd] = e.res.wr.rd_data;  // Issue order equals write order
    tag_cnt++;
  endtask

  // --------------------
  // Compare
  // --------------------
  task automatic check_field(string name, logic [63:0] exp_v, logic [63:0] act_v);
    if (exp_v !== act_v) begin
      err_val++;
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_bus(string bus, result_t act, ref exp_t q[$]);
    exp_t e;
    if (act.wr.valid) begin
      if (q.size() == 0) begin
        err_extra++;
        $display("At %0t the %s bus gave a result that no instruction expects", $time, bus);
      end else begin
        e = q.pop_front();
        if (e.due != cyc) begin
          err_time++;
          $display("At %0t the %s result came in cycle %0d instead of %0d",
                   $time, bus, cyc, e.due);
        end
        check_field({bus, ".rd_type"}, 64'(e.res.wr.rd_type), 64'(act.wr.rd_type));
        check_field({bus, ".rd_idx"}, 64'(e.res.wr.rd_idx), 64'(act.wr.rd_idx));
        check_field({bus, ".rd_data"}, e.res.wr.rd_data, act.wr.rd_data);
        check_field({bus, ".tag"}, 64'(e.res.tag), 64'(act.tag));
        check_field({bus, ".fflags"}, 64'(e.res.fflags), 64'(act.fflags));
      end
    end else if (q.size() != 0 && q[0].due <= cyc) begin
      e = q.pop_front();
      err_missing++;
      $display("At %0t the %s result with tag %0d never arrived", $time, bus, e.res.tag);
    end
  endtask

  always @(negedge clk) begin
    if (reset_n) begin
      check_bus("fast", fast_res, fast_q);
      check_bus("slow", slow_res, slow_q);
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    fpu_op_t op;
    issue   = '0;
    init_wr = '0;
    seed    = 32'h61ed;
    tag_cnt = '0;
    err_val = 0;
    err_time = 0;
    err_missing = 0;
    err_extra = 0;
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 32; i++) shadow[t][i] = '0;
    end
    wait (reset_n);
    idle(2);

    // Moves with x0 as source and sign extension
    preload();
    init_reg(GPR, 5'd0, 64'h0123456789abcdef);  // x0 must still read zero
    init_reg(FPR, 5'd4, 64'h123456789abcdef0);  // Negative low word
    issue_op(OP_FMV_X_W, 5'd16, 5'd1, 5'd0);
    issue_op(OP_FMV_X_W, 5'd17, 5'd4, 5'd0);
    issue_op(OP_FMV_W_X, 5'd16, 5'd1, 5'd0);
    issue_op(OP_FMV_W_X, 5'd17, 5'd0, 5'd0);
    issue_op(OP_FMV_X_D, 5'd18, 5'd2, 5'd0);
    issue_op(OP_FMV_D_X, 5'd18, 5'd3, 5'd0);
    issue_op(OP_FMV_D_X, 5'd19, 5'd0, 5'd0);
    for (int n = 0; n < 16; n++) begin
      op = fpu_op_t'(1 + (lcg_next() >> 8) % 4);
      issue_op(op, rand_idx(0, 32), rand_idx(0, 32), 5'd0);
    end
    idle(8);

    // Sign injection back to back
    preload();
    for (int n = 0; n < N_SGNJ; n++) begin
      op = fpu_op_t'(5 + (lcg_next() >> 8) % 6);
      issue_op(op, rand_idx(1, 31), rand_idx(1, 31), rand_idx(1, 31));
    end
    idle(8);

    // Compares into integer registers
    preload();
    load_specials();
    issue_op(OP_FEQ_D, 5'd16, 5'd1, 5'd2);
    issue_op(OP_FLT_D, 5'd17, 5'd2, 5'd1);
    issue_op(OP_FLE_D, 5'd18, 5'd1, 5'd2);
    issue_op(OP_FEQ_D, 5'd19, 5'd3, 5'd3);
    issue_op(OP_FLT_D, 5'd20, 5'd3, 5'd5);
    issue_op(OP_FEQ_D, 5'd21, 5'd4, 5'd5);
    issue_op(OP_FLE_D, 5'd22, 5'd5, 5'd5);
    for (int n = 0; n < 48; n++) begin
      op = fpu_op_t'(11 + (lcg_next() >> 8) % 3);
      issue_op(op, rand_idx(1, 31), rand_idx(1, 31), rand_idx(1, 31));
    end
    idle(8);

    // Min and max with sources kept apart from destinations
    preload();
    load_specials();
    issue_op(OP_FMIN_D, 5'd16, 5'd1, 5'd2);
    issue_op(OP_FMAX_D, 5'd17, 5'd1, 5'd2);
    issue_op(OP_FMIN_D, 5'd18, 5'd2, 5'd1);
    issue_op(OP_FMIN_D, 5'd19, 5'd3, 5'd5);
    issue_op(OP_FMAX_D, 5'd20, 5'd5, 5'd4);
    issue_op(OP_FMIN_D, 5'd21, 5'd3, 5'd4);
    issue_op(OP_FMAX_D, 5'd22, 5'd3, 5'd6);
    for (int n = 0; n < 24; n++) begin
      op = ((lcg_next() >> 8) & 1) ? OP_FMAX_D : OP_FMIN_D;
      issue_op(op, rand_idx(16, 16), rand_idx(1, 15), rand_idx(1, 15));
    end
    idle(8);

    // Forwarding chains
    preload();
    issue_op(OP_FSGNJ_D, 5'd20, 5'd1, 5'd2);
    issue_op(OP_FSGNJN_D, 5'd21, 5'd20, 5'd20);
    issue_op(OP_FSGNJX_D, 5'd22, 5'd21, 5'd20);
    issue_op(OP_FMV_X_D, 5'd20, 5'd22, 5'd0);
    issue_op(OP_FMV_D_X, 5'd23, 5'd20, 5'd0);
    issue_op(OP_FMAX_D, 5'd24, 5'd23, 5'd3);
    idle(1);
    issue_op(OP_FSGNJ_D, 5'd25, 5'd24, 5'd24);  // Slow to fast two cycles apart
    idle(1);
    issue_op(OP_FMIN_D, 5'd26, 5'd24, 5'd25);
    idle(8);

    // Mixed stream at one issue per cycle
    preload();
    for (int n = 0; n < N_STREAM; n++) begin
      op = fpu_op_t'(1 + (lcg_next() >> 8) % 15);
      issue_op(op, 5'(16 + n % 16), rand_idx(1, 15), rand_idx(1, 15));
    end
    idle(10);

    err_missing = err_missing + fast_q.size() + slow_q.size();
    $display("Errors: value %0d, timing %0d, missing %0d, extra %0d",
             err_val, err_time, err_missing, err_extra);
    if (err_val == 0 && err_time == 0 && err_missing == 0 && err_extra == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/fpu_pkg.sv
logic/fpu_decoder.sv
logic/operand_fwd.sv
logic/fp_regfile.sv
fpu_pipe/fpu_cmp_unit.sv
fpu_pipe/fpu_pipe.sv
logic/fpu_top.sv
tb/fpu_tb_clk.sv
tb/fpu_chk.sv
tb/fpu_tb.sv
